/* logic/dbg_pkg.sv */
// Debug module types and constants shared by the DMI register block,
// the testbench and the bound assertions

package dbg_pkg;

  // --------------------
  // DMI transport
  // --------------------
  typedef logic [6:0]  dmi_addr_t;
  typedef logic [31:0] dmi_data_t;

  typedef enum logic [1:0] {
    NOP   = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } dmi_op_e;

  typedef enum logic [1:0] {
    SUCCESS = 2'd0,
    FAILED  = 2'd2,
    BUSY    = 2'd3
  } dmi_resp_e;

  // --------------------
  // Debug register map
  // --------------------
  typedef enum logic [6:0] {
    DATA0      = 7'h04,
    DMCONTROL  = 7'h10,
    SBCS       = 7'h38,
    SBADDRESS0 = 7'h39,
    SBDATA0    = 7'h3C
  } dm_reg_e;

  // dmcontrol fields
  localparam int unsigned DmactiveBit  = 0;
  localparam int unsigned NdmresetBit  = 1;
  localparam int unsigned HaltreqBit   = 31;

  // sbcs fields
  localparam int unsigned SbbusyBit    = 21;
  localparam int unsigned SberrorLsb   = 12;
  localparam int unsigned SberrorWidth = 3;

  // Hold-off before the first debug request can reach the hart
  localparam int unsigned DmiDelCycles   = 500;
  localparam int unsigned DmiDelCntWidth = $clog2(DmiDelCycles + 1);

endpackage

/* logic/soc_pkg.sv */
// System bus widths, memory map and bus error codes for the SoC side
// of the debug subsystem

package soc_pkg;

  // --------------------
  // Bus geometry
  // --------------------
  localparam int unsigned BusAddrWidth = 32;
  localparam int unsigned BusDataWidth = 32;
  // Byte offset bits dropped for word addressing
  localparam int unsigned ByteOffWidth = 2;

  // --------------------
  // Address map
  // --------------------
  localparam logic [BusAddrWidth-1:0] RomBase = 32'h0001_0000;
  localparam int unsigned RomWords    = 16;
  localparam int unsigned RomIdxWidth = $clog2(RomWords);

  localparam logic [BusAddrWidth-1:0] RamBase = 32'h8000_0000;
  localparam int unsigned RamWords    = 256;
  localparam int unsigned RamIdxWidth = $clog2(RamWords);

  // Boot ROM word i holds RomSeed + i
  localparam logic [BusDataWidth-1:0] RomSeed = 32'hB007_0000;

  function automatic logic [BusDataWidth-1:0] rom_word(input logic [RomIdxWidth-1:0] idx);
    return RomSeed + BusDataWidth'(idx);
  endfunction

  // System bus access error codes, as reported in sbcs.sberror
  typedef enum logic [2:0] {
    NONE     = 3'd0,
    BAD_ADDR = 3'd2
  } sb_err_e;

endpackage

/* logic/sys_bus_if.sv */
// Single-word request/grant system bus between the access engine and
// the memory decoder. req holds until gnt, rvalid follows a grant by
// one cycle for reads and writes alike

interface sys_bus_if;
  import soc_pkg::*;

  // Initiator side
  logic                    req;
  logic                    we;
  logic [BusAddrWidth-1:0] addr;
  logic [BusDataWidth-1:0] wdata;

  // Target side with err qualifying rvalid
  logic                    gnt;
  logic                    rvalid;
  logic [BusDataWidth-1:0] rdata;
  logic                    err;

  modport initiator (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport target (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

/* logic/dm_csrs.sv */
// Debug module register block behind the DMI handshake. Owns dmcontrol,
// the system bus access registers and the debug request hold-off window

module dm_csrs (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // DMI request
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  dbg_pkg::dmi_addr_t                  req_addr_i,
  input  dbg_pkg::dmi_op_e                    req_op_i,
  input  dbg_pkg::dmi_data_t                  req_data_i,
  // DMI response
  output logic                                resp_valid_o,
  input  logic                                resp_ready_i,
  output dbg_pkg::dmi_data_t                  resp_data_o,
  output dbg_pkg::dmi_resp_e                  resp_code_o,
  // To the hart
  output logic                                dm_rst_o,
  output logic                                debug_req_o,
  // System bus access engine
  output logic                                sba_rd_start_o,
  output logic                                sba_wr_start_o,
  output logic [soc_pkg::BusAddrWidth-1:0]    sba_addr_o,
  output logic [soc_pkg::BusDataWidth-1:0]    sba_wdata_o,
  output logic                                sba_err_clr_o,
  input  logic                                sba_busy_i,
  input  logic                                sba_done_i,
  input  logic [soc_pkg::BusDataWidth-1:0]    sba_rdata_i,
  input  soc_pkg::sb_err_e                    sba_err_i
);
  import dbg_pkg::*;
  import soc_pkg::*;

  logic      resp_valid_q;
  dmi_data_t resp_data_q;
  dmi_resp_e resp_code_q;
  dmi_data_t resp_data_d;
  dmi_resp_e resp_code_d;

  dmi_data_t data0_q;
  dmi_data_t dmcontrol_q;
  dmi_data_t sbaddress0_q;
  dmi_data_t sbdata0_q;
  dmi_data_t sbcs_rd;

  logic accept;
  logic is_sb_reg;
  logic wr_ok;
  logic sba_err_set;
  logic sba_read_q;
  logic rd_start_q;
  logic wr_start_q;
  logic err_clr_q;

  logic [DmiDelCntWidth-1:0] del_cnt_q;

  // --------------------
  // DMI handshake
  // --------------------
  // One response in flight at a time so back-pressure stalls requests
  assign req_ready_o = ~resp_valid_q;
  assign accept      = req_valid_i & req_ready_o;

  assign is_sb_reg   = (req_addr_i == SBADDRESS0) || (req_addr_i == SBDATA0);
  assign sba_err_set = (sba_err_i != NONE);
  // Access registers are locked while the engine is busy
  assign wr_ok       = accept && (req_op_i == WRITE) && !(is_sb_reg && sba_busy_i);

  always_comb begin
    sbcs_rd = '0;
    sbcs_rd[SbbusyBit] = sba_busy_i;
    sbcs_rd[SberrorLsb +: SberrorWidth] = sba_err_i;
  end

  always_comb begin
    resp_data_d = '0;
    resp_code_d = SUCCESS;
    case (req_op_i)
      NOP: begin
        resp_code_d = SUCCESS;
      end
      READ: begin
        case (req_addr_i)
          DATA0:      resp_data_d = data0_q;
          DMCONTROL:  resp_data_d = dmcontrol_q;
          SBCS:       resp_data_d = sbcs_rd;
          SBADDRESS0: resp_data_d = sbaddress0_q;
          SBDATA0:    resp_data_d = sbdata0_q;
          default:    resp_data_d = '0;
        endcase
      end
      WRITE: begin
        if (is_sb_reg && sba_busy_i) begin
          resp_code_d = BUSY;
        end
      end
      default: begin
        resp_code_d = FAILED;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_data_q <= resp_data_d;
      resp_code_q <= resp_code_d;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;
  assign resp_code_o  = resp_code_q;

  // --------------------
  // Register file
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data0_q      <= '0;
      dmcontrol_q  <= '0;
      sbaddress0_q <= '0;
      sbdata0_q    <= '0;
      sba_read_q   <= 1'b0;
      rd_start_q   <= 1'b0;
      wr_start_q   <= 1'b0;
      err_clr_q    <= 1'b0;
    end else begin
      // Start pulses only when no error is recorded
      rd_start_q <= wr_ok && (req_addr_i == SBADDRESS0) && !sba_err_set;
      wr_start_q <= wr_ok && (req_addr_i == SBDATA0) && !sba_err_set;
      // Any nonzero sberror written back clears it
      err_clr_q  <= wr_ok && (req_addr_i == SBCS) &&
                    (|req_data_i[SberrorLsb +: SberrorWidth]);
      if (rd_start_q) begin
        sba_read_q <= 1'b1;
      end else if (wr_start_q) begin
        sba_read_q <= 1'b0;
      end
      // Read data lands even while another register is written
      if (sba_done_i && sba_read_q) begin
        sbdata0_q <= sba_rdata_i;
      end
      if (wr_ok) begin
        case (req_addr_i)
          DATA0:      data0_q      <= req_data_i;
          DMCONTROL:  dmcontrol_q  <= req_data_i;
          SBADDRESS0: sbaddress0_q <= req_data_i;
          SBDATA0:    sbdata0_q    <= req_data_i;
          default:    ;
        endcase
      end
    end
  end

  assign sba_rd_start_o = rd_start_q;
  assign sba_wr_start_o = wr_start_q;
  assign sba_err_clr_o  = err_clr_q;
  assign sba_addr_o     = sbaddress0_q;
  assign sba_wdata_o    = sbdata0_q;

  // --------------------
  // Hart control
  // --------------------
  // Counts down once after reset and masks debug requests until zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= DmiDelCntWidth'(DmiDelCycles);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  assign dm_rst_o    = dmcontrol_q[NdmresetBit];
  assign debug_req_o = (del_cnt_q == '0) && dmcontrol_q[HaltreqBit] &&
                       dmcontrol_q[DmactiveBit];

endmodule

/* logic/dm_sba.sv */
// System bus access engine. Runs one single-word read or write per start
// pulse and keeps a sticky error until the register block clears it

module dm_sba (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             rd_start_i,
  input  logic                             wr_start_i,
  input  logic [soc_pkg::BusAddrWidth-1:0] addr_i,
  input  logic [soc_pkg::BusDataWidth-1:0] wdata_i,
  input  logic                             err_clr_i,
  output logic                             busy_o,
  output logic                             done_o,
  output logic [soc_pkg::BusDataWidth-1:0] rdata_o,
  output soc_pkg::sb_err_e                 err_o,
  sys_bus_if.initiator                     bus
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT
  } state_e;

  state_e                  state_q;
  sb_err_e                 err_q;
  logic                    we_q;
  logic [BusAddrWidth-1:0] addr_q;
  logic [BusDataWidth-1:0] wdata_q;

  // --------------------
  // Access FSM
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (rd_start_i || wr_start_i) state_q <= REQ;
        REQ:     if (bus.gnt) state_q <= WAIT;
        WAIT:    if (bus.rvalid) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Access attributes captured at start
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && (rd_start_i || wr_start_i)) begin
      we_q    <= wr_start_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  // Sticky error
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= NONE;
    end else if (state_q == WAIT && bus.rvalid && bus.err) begin
      err_q <= BAD_ADDR;
    end else if (err_clr_i) begin
      err_q <= NONE;
    end
  end

  assign bus.req   = (state_q == REQ);
  assign bus.we    = we_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;

  assign busy_o  = (state_q != IDLE);
  assign done_o  = (state_q == WAIT) && bus.rvalid;
  assign rdata_o = bus.rdata;
  assign err_o   = err_q;

endmodule

/* logic/soc_mem.sv */
// Memory side of the system bus: boot ROM, scratch RAM and a decode
// error for anything outside the map. Grants at once, answers a cycle later

module soc_mem (
  input  logic     clk_i,
  input  logic     rst_ni,
  sys_bus_if.target bus
);
  import soc_pkg::*;

  logic [BusAddrWidth-1:0] rom_off;
  logic [BusAddrWidth-1:0] ram_off;
  logic                    rom_hit;
  logic                    ram_hit;
  logic [RomIdxWidth-1:0]  rom_idx;
  logic [RamIdxWidth-1:0]  ram_idx;
  logic [BusDataWidth-1:0] rd_word;

  logic [BusDataWidth-1:0] ram_q [RamWords];
  logic                    rvalid_q;
  logic                    err_q;
  logic [BusDataWidth-1:0] rdata_q;

  // --------------------
  // Address decode
  // --------------------
  // Offsets wrap below the base, so one compare covers both bounds
  assign rom_off = bus.addr - RomBase;
  assign ram_off = bus.addr - RamBase;
  assign rom_hit = (rom_off[BusAddrWidth-1:ByteOffWidth] < RomWords);
  assign ram_hit = (ram_off[BusAddrWidth-1:ByteOffWidth] < RamWords);
  assign rom_idx = rom_off[ByteOffWidth +: RomIdxWidth];
  assign ram_idx = ram_off[ByteOffWidth +: RamIdxWidth];

  always_comb begin
    if (rom_hit) begin
      rd_word = rom_word(rom_idx);
    end else if (ram_hit) begin
      rd_word = ram_q[ram_idx];
    end else begin
      rd_word = '0;
    end
  end

  // --------------------
  // Storage
  // --------------------
  // ROM writes are dropped silently
  always_ff @(posedge clk_i) begin
    if (bus.req && bus.we && ram_hit) begin
      ram_q[ram_idx] <= bus.wdata;
    end
  end

  // Response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      err_q    <= bus.req && !rom_hit && !ram_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= rd_word;
    end
  end

  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.err    = err_q;
  assign bus.rdata  = rdata_q;

endmodule

/* logic/dbg_subsystem.sv */
// Debug subsystem top level. DMI requests from the host drive the debug
// register block, whose bus access engine reaches ROM and RAM

module dbg_subsystem (
  input  logic               clk_i,
  input  logic               rst_ni,
  // DMI
  input  logic               dmi_req_valid_i,
  output logic               dmi_req_ready_o,
  input  dbg_pkg::dmi_addr_t dmi_req_addr_i,
  input  dbg_pkg::dmi_op_e   dmi_req_op_i,
  input  dbg_pkg::dmi_data_t dmi_req_data_i,
  output logic               dmi_resp_valid_o,
  input  logic               dmi_resp_ready_i,
  output dbg_pkg::dmi_data_t dmi_resp_data_o,
  output dbg_pkg::dmi_resp_e dmi_resp_code_o,
  // Hart control
  output logic               dm_rst_o,
  output logic               debug_req_o
);
  import soc_pkg::*;

  logic                    sba_rd_start;
  logic                    sba_wr_start;
  logic [BusAddrWidth-1:0] sba_addr;
  logic [BusDataWidth-1:0] sba_wdata;
  logic                    sba_err_clr;
  logic                    sba_busy;
  logic                    sba_done;
  logic [BusDataWidth-1:0] sba_rdata;
  sb_err_e                 sba_err;

  sys_bus_if sys_bus ();

  dm_csrs i_dm_csrs (
    .clk_i          ( clk_i            ),
    .rst_ni         ( rst_ni           ),
    .req_valid_i    ( dmi_req_valid_i  ),
    .req_ready_o    ( dmi_req_ready_o  ),
    .req_addr_i     ( dmi_req_addr_i   ),
    .req_op_i       ( dmi_req_op_i     ),
    .req_data_i     ( dmi_req_data_i   ),
    .resp_valid_o   ( dmi_resp_valid_o ),
    .resp_ready_i   ( dmi_resp_ready_i ),
    .resp_data_o    ( dmi_resp_data_o  ),
    .resp_code_o    ( dmi_resp_code_o  ),
    .dm_rst_o       ( dm_rst_o         ),
    .debug_req_o    ( debug_req_o      ),
    .sba_rd_start_o ( sba_rd_start     ),
    .sba_wr_start_o ( sba_wr_start     ),
    .sba_addr_o     ( sba_addr         ),
    .sba_wdata_o    ( sba_wdata        ),
    .sba_err_clr_o  ( sba_err_clr      ),
    .sba_busy_i     ( sba_busy         ),
    .sba_done_i     ( sba_done         ),
    .sba_rdata_i    ( sba_rdata        ),
    .sba_err_i      ( sba_err          )
  );

  dm_sba i_dm_sba (
    .clk_i      ( clk_i        ),
    .rst_ni     ( rst_ni       ),
    .rd_start_i ( sba_rd_start ),
    .wr_start_i ( sba_wr_start ),
    .addr_i     ( sba_addr     ),
    .wdata_i    ( sba_wdata    ),
    .err_clr_i  ( sba_err_clr  ),
    .busy_o     ( sba_busy     ),
    .done_o     ( sba_done     ),
    .rdata_o    ( sba_rdata    ),
    .err_o      ( sba_err      ),
    .bus        ( sys_bus      )
  );

  soc_mem i_soc_mem (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .bus    ( sys_bus )
  );

endmodule

/* dv/dbg_subsystem_assert.sv */
// Concurrent checks bound into the debug subsystem top level. Covers the
// DMI handshake, the system bus request and the debug request hold-off

module dbg_subsystem_assert (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               dmi_req_ready_o,
  input logic               dmi_resp_valid_o,
  input logic               dmi_resp_ready_i,
  input dbg_pkg::dmi_data_t dmi_resp_data_o,
  input dbg_pkg::dmi_resp_e dmi_resp_code_o,
  input logic               debug_req_o,
  input logic               bus_req,
  input logic               bus_gnt
);
  import dbg_pkg::*;

  int unsigned fail_cnt = 0;
  logic [DmiDelCntWidth-1:0] since_rst_q;

  // Saturating count of cycles since reset release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_rst_q <= '0;
    end else if (since_rst_q != DmiDelCntWidth'(DmiDelCycles)) begin
      since_rst_q <= since_rst_q + 1'b1;
    end
  end

  ready_low_while_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmi_resp_valid_o |-> !dmi_req_ready_o)
    else begin
      $error("DMI request ready is high while a response is pending");
      fail_cnt++;
    end

  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmi_resp_valid_o && !dmi_resp_ready_i |=>
      dmi_resp_valid_o && $stable(dmi_resp_data_o) && $stable(dmi_resp_code_o))
    else begin
      $error("DMI response changed while stalled");
      fail_cnt++;
    end

  bus_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req && !bus_gnt |=> bus_req)
    else begin
      $error("System bus request dropped before grant");
      fail_cnt++;
    end

  debug_req_hold_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (since_rst_q < DmiDelCntWidth'(DmiDelCycles)) |-> !debug_req_o)
    else begin
      $error("Debug request raised inside the hold-off window");
      fail_cnt++;
    end

endmodule

bind dbg_subsystem dbg_subsystem_assert i_dbg_subsystem_assert (
  .clk_i            ( clk_i            ),
  .rst_ni           ( rst_ni           ),
  .dmi_req_ready_o  ( dmi_req_ready_o  ),
  .dmi_resp_valid_o ( dmi_resp_valid_o ),
  .dmi_resp_ready_i ( dmi_resp_ready_i ),
  .dmi_resp_data_o  ( dmi_resp_data_o  ),
  .dmi_resp_code_o  ( dmi_resp_code_o  ),
  .debug_req_o      ( debug_req_o      ),
  .bus_req          ( sys_bus.req      ),
  .bus_gnt          ( sys_bus.gnt      )
);

/* dv/tb_dbg_subsystem.sv */
// Testbench for the debug subsystem. Replays DMI requests from the golden
// file under random response back-pressure and checks data, response codes
// and the hart control pins

module tb_dbg_subsystem;
  import dbg_pkg::*;

  localparam int unsigned ClkPeriod    = 40;
  localparam int unsigned DriveDly     = 4;
  localparam int unsigned ResetCycles  = 16;
  localparam int unsigned WaitLimit    = 64;
  localparam int unsigned PollLimit    = 32;
  localparam int unsigned DbgWaitLimit = 2 * DmiDelCycles;
  localparam int unsigned RecWords     = 6;
  localparam int unsigned MaxRecs      = 64;

  // Golden record ops beyond plain DMI requests
  localparam logic [31:0] OpPoll    = 32'h3;
  localparam logic [31:0] OpWaitDbg = 32'h4;
  localparam logic [31:0] OpPins    = 32'h5;
  localparam logic [31:0] OpEnd     = 32'hF;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  logic      req_ready;
  dmi_addr_t req_addr;
  dmi_op_e   req_op;
  dmi_data_t req_data;
  logic      resp_valid;
  logic      resp_ready;
  dmi_data_t resp_data;
  dmi_resp_e resp_code;
  logic      dm_rst;
  logic      debug_req;

  logic [31:0] golden [RecWords*MaxRecs];
  logic [15:0] lfsr_q;
  int unsigned err_cnt;
  int unsigned timeout_cnt;
  int unsigned rec_idx;
  int unsigned edges_since_rst;
  logic        timed_out;

  dbg_subsystem i_dut (
    .clk_i            ( clk        ),
    .rst_ni           ( rst_n      ),
    .dmi_req_valid_i  ( req_valid  ),
    .dmi_req_ready_o  ( req_ready  ),
    .dmi_req_addr_i   ( req_addr   ),
    .dmi_req_op_i     ( req_op     ),
    .dmi_req_data_i   ( req_data   ),
    .dmi_resp_valid_o ( resp_valid ),
    .dmi_resp_ready_i ( resp_ready ),
    .dmi_resp_data_o  ( resp_data  ),
    .dmi_resp_code_o  ( resp_code  ),
    .dm_rst_o         ( dm_rst     ),
    .debug_req_o      ( debug_req  )
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  // Rising edges seen since reset release
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edges_since_rst <= 0;
    end else begin
      edges_since_rst <= edges_since_rst + 1;
    end
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int unsigned n, output int unsigned val);
    int unsigned i;
    val = 0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = (val << 1) | 32'(lfsr_q[0]);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t: record %0d, %s: got %h, expected %h",
               $time, rec_idx, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_cnt++;
    timed_out = 1'b1;
    $display("Timeout at %0t in record %0d: %s", $time, rec_idx, what);
  endtask

  // One DMI request and its response, entered and left just after a rising edge
  task automatic dmi_access(input dmi_op_e op, input dmi_addr_t addr,
                            input dmi_data_t data, input logic bp,
                            output dmi_data_t rdata, output dmi_resp_e code);
    int unsigned delay;
    int unsigned cnt;
    rdata = '0;
    code  = SUCCESS;
    delay = 0;
    if (bp) begin
      draw_bits(2, delay);
    end
    req_valid = 1'b1;
    req_addr  = addr;
    req_op    = op;
    req_data  = data;
    cnt = 0;
    @(negedge clk);
    while (!req_ready && cnt < WaitLimit) begin
      cnt++;
      @(negedge clk);
    end
    @(posedge clk);
    #DriveDly;
    req_valid = 1'b0;
    if (cnt >= WaitLimit) begin
      report_timeout("DMI request was never accepted");
      return;
    end
    // Hold off the response for a few cycles
    repeat (delay) begin
      @(posedge clk);
      #DriveDly;
    end
    resp_ready = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!resp_valid && cnt < WaitLimit) begin
      cnt++;
      @(negedge clk);
    end
    if (resp_valid) begin
      rdata = resp_data;
      code  = resp_code;
    end
    @(posedge clk);
    #DriveDly;
    resp_ready = 1'b0;
    if (cnt >= WaitLimit) begin
      report_timeout("DMI response never arrived");
    end
  endtask

  // Read SBCS until sbbusy clears, then check the final value
  task automatic poll_sbcs(input dmi_data_t exp, input logic bp);
    dmi_data_t   rdata;
    dmi_resp_e   code;
    int unsigned cnt;
    cnt = 0;
    do begin
      dmi_access(READ, SBCS, '0, bp, rdata, code);
      cnt++;
    end while (rdata[SbbusyBit] && !timed_out && cnt < PollLimit);
    if (timed_out) begin
      return;
    end
    if (rdata[SbbusyBit]) begin
      report_timeout("sbbusy never cleared while polling SBCS");
    end else begin
      check_value("SBCS after polling", rdata, exp);
      check_value("SBCS poll code", 32'(code), 32'(SUCCESS));
    end
  endtask

  task automatic wait_debug_req(input logic level, input logic [31:0] exp_edges);
    int unsigned cnt;
    cnt = 0;
    @(negedge clk);
    while (debug_req !== level && cnt < DbgWaitLimit) begin
      cnt++;
      @(negedge clk);
    end
    if (debug_req !== level) begin
      report_timeout("debug_req_o never reached the expected level");
    end else begin
      check_value("cycles until debug_req_o change", edges_since_rst, exp_edges);
    end
    @(posedge clk);
    #DriveDly;
  endtask

  // exp packs {debug_req_o, dm_rst_o}
  task automatic check_pins(input logic [1:0] exp);
    @(negedge clk);
    check_value("debug_req_o", 32'(debug_req), 32'(exp[1]));
    check_value("dm_rst_o", 32'(dm_rst), 32'(exp[0]));
    @(posedge clk);
    #DriveDly;
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    logic [31:0] exp_code;
    logic [31:0] bp;
    dmi_data_t   rdata;
    dmi_resp_e   code;
    logic        done;
    int unsigned assert_fails;

    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req_addr    = '0;
    req_op      = NOP;
    req_data    = '0;
    resp_ready  = 1'b0;
    err_cnt     = 0;
    timeout_cnt = 0;
    rec_idx     = 0;
    timed_out   = 1'b0;
    lfsr_q      = 16'h0001;
    done        = 1'b0;
    $readmemh("dv/dmi_golden.txt", golden);

    repeat (ResetCycles) @(posedge clk);
    #DriveDly;
    rst_n = 1'b1;
    @(posedge clk);
    #DriveDly;

    while (!done && !timed_out && rec_idx < MaxRecs) begin
      op       = golden[rec_idx*RecWords];
      addr     = golden[rec_idx*RecWords+1];
      wdata    = golden[rec_idx*RecWords+2];
      exp_data = golden[rec_idx*RecWords+3];
      exp_code = golden[rec_idx*RecWords+4];
      bp       = golden[rec_idx*RecWords+5];
      case (op)
        32'h0, 32'h1, 32'h2: begin
          dmi_access(dmi_op_e'(op[1:0]), addr[6:0], wdata, bp[0], rdata, code);
          if (!timed_out) begin
            if (op == 32'h1) begin
              check_value("read data", rdata, exp_data);
            end
            check_value("response code", 32'(code), exp_code);
          end
        end
        OpPoll:    poll_sbcs(exp_data, bp[0]);
        OpWaitDbg: wait_debug_req(wdata[0], exp_data);
        OpPins:    check_pins(wdata[1:0]);
        OpEnd:     done = 1'b1;
        default: begin
          err_cnt++;
          $display("Golden record %0d holds an unknown op %h", rec_idx, op);
          done = 1'b1;
        end
      endcase
      rec_idx++;
    end
    if (!done && !timed_out) begin
      err_cnt++;
      $display("Golden file ended without an end record");
    end

    assert_fails = i_dut.i_dbg_subsystem_assert.fail_cnt;
    $display("Run complete: %0d check errors, %0d assertion failures, %0d timeouts",
             err_cnt, assert_fails, timeout_cnt);
    if (err_cnt == 0 && assert_fails == 0 && timeout_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* dv/dmi_golden.txt */
// op addr wdata exp_data exp_code bp, all hex. op 0 NOP 1 READ 2 WRITE 3 poll SBCS
// 4 wait debug_req (wdata level, exp_data cycles) 5 pins (wdata {debug_req,dm_rst}) F end
2 10 80000001 00000000 0 1
5 00 00000000 00000000 0 0
4 00 00000001 000001F4 0 0
5 00 00000002 00000000 0 0
2 10 00000003 00000000 0 1
5 00 00000001 00000000 0 0
2 10 00000001 00000000 0 1
5 00 00000000 00000000 0 0
1 10 00000000 00000001 0 1
2 04 DEADBEEF 00000000 0 1
1 04 00000000 DEADBEEF 0 1
2 22 FFFFFFFF 00000000 0 1
1 22 00000000 00000000 0 1
0 00 00000000 00000000 0 1
// Boot ROM read, word 5
2 39 00010014 00000000 0 1
3 38 00000000 00000000 0 1
1 3C 00000000 B0070005 0 1
// RAM writes then read back
2 39 80000010 00000000 0 1
3 38 00000000 00000000 0 1
2 3C CAFE0001 00000000 0 1
3 38 00000000 00000000 0 1
2 39 80000024 00000000 0 1
3 38 00000000 00000000 0 1
2 3C CAFE0002 00000000 0 1
3 38 00000000 00000000 0 1
2 39 80000010 00000000 0 0
2 3C 11111111 00000000 3 1
3 38 00000000 00000000 0 1
1 3C 00000000 CAFE0001 0 1
2 39 80000024 00000000 0 1
3 38 00000000 00000000 0 1
1 3C 00000000 CAFE0002 0 1
// Unmapped access, blocked access, clear and retry
2 39 40000000 00000000 0 1
3 38 00000000 00002000 0 1
1 3C 00000000 00000000 0 1
2 39 80000010 00000000 0 0
1 38 00000000 00002000 0 1
1 3C 00000000 00000000 0 1
1 39 00000000 80000010 0 1
2 38 00002000 00000000 0 1
1 38 00000000 00000000 0 1
2 39 80000010 00000000 0 1
3 38 00000000 00000000 0 1
1 3C 00000000 CAFE0001 0 1
F 00 00000000 00000000 0 0

/* build.f */
logic/dbg_pkg.sv
logic/soc_pkg.sv
logic/sys_bus_if.sv
logic/dm_csrs.sv
logic/dm_sba.sv
logic/soc_mem.sv
logic/dbg_subsystem.sv
dv/dbg_subsystem_assert.sv
dv/tb_dbg_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the debug subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f build.f \
  --top-module tb_dbg_subsystem -Mdir obj_dir -o sim_dbg_subsystem

./obj_dir/sim_dbg_subsystem +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
